// ==== common/spi_macros.svh ====
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// width of one byte on the serial lines
`define SPI_DATA_W 8

// number of entries in the transmit and the receive queue
`define SPI_FIFO_DEPTH 4

// APB address width with the registers on word offsets
`define SPI_APB_AW 5

// conf after reset holds half_div 3 in bits 15:8 and mode 0 in bits 1:0
`define SPI_CONF_RESET 16'h0300

`endif

// ==== common/spi_pkg.sv ====
`include "spi_macros.svh"

package spi_pkg;

  // register offsets as seen on paddr
  typedef enum logic [`SPI_APB_AW-1:0] {
    REG_CONF   = 'h00,
    REG_STATUS = 'h04,
    REG_TXDATA = 'h08,
    REG_RXDATA = 'h0C
  } spi_reg_addr_t;

  // clock mode with cpol in the upper bit
  typedef struct packed {
    logic cpol; // level of sclk between transfers
    logic cpha; // set means data is sampled on the trailing edge
  } spi_mode_t;

  // conf register, 16 bits
  //   15:8  half_div, sclk half-period in clk cycles minus one
  //   7:2   reserved, stored and read back as written
  //   1:0   mode
  typedef struct packed {
    logic [7:0] half_div;
    logic [5:0] rsvd;
    spi_mode_t  mode;
  } spi_conf_t;

  // one transmit queue entry, last sits right above the data byte
  typedef struct packed {
    logic                   last; // release chip select after this byte
    logic [`SPI_DATA_W-1:0] data;
  } spi_tx_entry_t;

endpackage

// ==== design/apb_spi_regs.sv ====
`timescale 1ns/1ns
`include "spi_macros.svh"

module apb_spi_regs (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [`SPI_APB_AW-1:0]                paddr,
  input  logic [31:0]                           pwdata,
  output logic [31:0]                           prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic [15:0]                           conf,
  input  logic                                  busy,
  output logic                                  tx_push,
  output spi_pkg::spi_tx_entry_t                tx_wdata,
  input  logic                                  tx_full,
  output logic                                  rx_pop,
  input  logic [`SPI_DATA_W-1:0]                rx_rdata,
  input  logic                                  rx_empty,
  input  logic [$clog2(`SPI_FIFO_DEPTH+1)-1:0]  rx_count
);
  import spi_pkg::*;

  localparam int RXCW = $clog2(`SPI_FIFO_DEPTH + 1);

  logic access;
  logic wr_access;
  logic rd_access;
  logic sel_conf;
  logic sel_txdata;
  logic sel_rxdata;

  assign pready = 1'b1; // every access completes in its first access cycle

  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign rd_access = access && !pwrite;

  assign sel_conf   = (paddr == REG_CONF);
  assign sel_txdata = (paddr == REG_TXDATA);
  assign sel_rxdata = (paddr == REG_RXDATA);

  // queue strobes fire in the access cycle itself
  assign tx_push  = wr_access && sel_txdata && !tx_full;
  assign tx_wdata = '{last: pwdata[`SPI_DATA_W], data: pwdata[`SPI_DATA_W-1:0]};
  assign rx_pop   = rd_access && sel_rxdata && !rx_empty;

  assign pslverr = (wr_access && sel_txdata && tx_full) ||
                   (rd_access && sel_rxdata && rx_empty) ||
                   (wr_access && sel_conf && busy);   // conf is frozen during traffic

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      conf <= `SPI_CONF_RESET;
    end else if (wr_access && sel_conf && !busy) begin
      conf <= pwdata[15:0];
    end
  end

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        REG_CONF: begin
          prdata[15:0] = conf;
        end
        REG_STATUS: begin
          prdata[0]         = busy;
          prdata[1]         = tx_full;
          prdata[2]         = rx_empty;
          prdata[4 +: RXCW] = rx_count;
        end
        REG_RXDATA: begin
          if (!rx_empty) begin
            prdata[`SPI_DATA_W-1:0] = rx_rdata; // empty queue reads as zero
          end
        end
        default: prdata = '0;
      endcase
    end
  end

endmodule

// ==== design/spi_fifo.sv ====
`timescale 1ns/1ns
`include "spi_macros.svh"

module spi_fifo #(
  parameter type payload_t = logic [`SPI_DATA_W-1:0],
  parameter int  depth     = `SPI_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         push,
  input  payload_t                     wdata,
  output logic                         full,
  input  logic                         pop,
  output payload_t                     rdata,
  output logic                         empty,
  output logic [$clog2(depth+1)-1:0]   count
);

  localparam int PW = (depth > 1) ? $clog2(depth) : 1;
  localparam int CW = $clog2(depth + 1);

  payload_t      mem [depth];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    return (ptr == PW'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push && !full; // overflow and underflow are dropped here
  assign do_pop  = pop && !empty;

  assign full  = (count == CW'(depth));
  assign empty = (count == '0);
  assign rdata = mem[rd_ptr]; // head is visible without a pop

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/spi_master_top.sv ====
`timescale 1ns/1ns
`include "spi_macros.svh"

module spi_master_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`SPI_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   miso,
  output logic                   mosi,
  output logic                   sclk,
  output logic                   cs_n
);
  import spi_pkg::*;

  localparam int RXCW = $clog2(`SPI_FIFO_DEPTH + 1);

  logic [15:0]            conf;
  logic                   busy;
  logic                   tx_push;
  logic                   tx_pop;
  logic                   tx_full;
  logic                   tx_empty;
  spi_tx_entry_t          tx_wdata;
  spi_tx_entry_t          tx_entry;
  logic                   rx_push;
  logic                   rx_pop;
  logic                   rx_full;
  logic                   rx_empty;
  logic [`SPI_DATA_W-1:0] rx_byte;
  logic [`SPI_DATA_W-1:0] rx_rdata;
  logic [RXCW-1:0]        rx_count;
  logic                   start;
  logic                   done;

  apb_spi_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .conf(conf), .busy(busy),
    .tx_push(tx_push), .tx_wdata(tx_wdata), .tx_full(tx_full),
    .rx_pop(rx_pop), .rx_rdata(rx_rdata), .rx_empty(rx_empty), .rx_count(rx_count)
  );

  spi_fifo #(.payload_t(spi_tx_entry_t), .depth(`SPI_FIFO_DEPTH)) u_tx_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(tx_push), .wdata(tx_wdata), .full(tx_full),
    .pop(tx_pop), .rdata(tx_entry), .empty(tx_empty), .count()
  );

  spi_fifo #(.payload_t(logic [`SPI_DATA_W-1:0]), .depth(`SPI_FIFO_DEPTH)) u_rx_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(rx_push), .wdata(rx_byte), .full(rx_full),
    .pop(rx_pop), .rdata(rx_rdata), .empty(rx_empty), .count(rx_count)
  );

  spi_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .tx_empty(tx_empty), .tx_entry(tx_entry), .tx_pop(tx_pop),
    .rx_full(rx_full), .rx_push(rx_push),
    .done(done), .start(start), .cs_n(cs_n), .busy(busy),
    .half_div(conf[15:8])
  );

  spi_xcvr u_xcvr (
    .clk(clk), .rst_n(rst_n), .conf(conf),
    .start(start), .tx(tx_entry.data), .rx(rx_byte), .done(done),
    .miso(miso), .mosi(mosi), .sclk(sclk)
  );

endmodule

// ==== dv/spi_master_tb.sv ====
`timescale 1ns/1ns
`include "spi_macros.svh"

module spi_master_tb;
  import spi_pkg::*;

  localparam int NROWS = 8;
  localparam int NXFER = NROWS + 9;  // table rows plus back-pressure and conf-lock transfers
  localparam longint LIMIT_NS = longint'(NXFER) * 16 * 257 * 40 + 200000;

  logic                   clk;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`SPI_APB_AW-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   miso;
  logic                   mosi;
  logic                   sclk;
  logic                   cs_n;

  // the stimulus table columns are mode, half_div, master byte, slave byte and last
  spi_mode_t  row_mode [NROWS];
  logic [7:0] row_hd   [NROWS];
  logic [7:0] row_mb   [NROWS];
  logic [7:0] row_sb   [NROWS];
  logic       row_last [NROWS];

  // slave model state
  logic [7:0] miso_q[$];
  logic [7:0] mosi_q[$];
  spi_mode_t  cur_mode;
  logic [7:0] cur_hd;
  logic [7:0] s_tx;
  logic [7:0] s_rx;
  int         s_cnt;
  int         cs_rises;
  logic       cs_prev;
  logic       sclk_prev;
  time        lead_t;

  logic [7:0]  bp_m [8];
  logic [7:0]  bp_s [8];
  logic [31:0] rdata;
  logic        err;
  int          i;
  int          n;
  int          first;
  int          rises0;

  spi_master_top UUT (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .miso(miso), .mosi(mosi), .sclk(sclk), .cs_n(cs_n)
  );

  always #20 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic apb_write(input logic [`SPI_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    slverr = pslverr;
    check("pready", pready, 1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [`SPI_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data   = prdata; // sampled in the middle of the access cycle before the pop edge
    slverr = pslverr;
    check("pready", pready, 1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
    logic [31:0] st;
    logic        e;
    do begin
      apb_read(REG_STATUS, st, e);
      check("pslverr", e, 0);
    end while ((st & mask) != value);
  endtask

  task automatic set_conf(input spi_mode_t mode, input logic [7:0] hd);
    logic e;
    apb_write(REG_CONF, {16'h0, hd, 6'h0, mode}, e);
    check("pslverr", e, 0);
    cur_mode = mode;
    cur_hd   = hd;
  endtask

  task automatic read_rx(input logic [7:0] exp_s, input logic [7:0] exp_m);
    logic [31:0] d;
    logic        e;
    apb_read(REG_RXDATA, d, e);
    check("pslverr", e, 0);
    check("prdata", d, {24'h0, exp_s});
    check("mosi_q size", (mosi_q.size() > 0), 1);
    check("slave mosi byte", mosi_q.pop_front(), exp_m);
  endtask

  function automatic logic next_msb();
    return (miso_q.size() > 0) ? miso_q[0][7] : 1'b0;
  endfunction

  // behavioral SPI slave following the mode the testbench configured
  always @(sclk or cs_n) begin
    if (cs_n !== cs_prev) begin
      if (!cs_n) begin
        s_cnt = 0;
        miso  <= next_msb();
      end else begin
        cs_rises++;
      end
    end else if (!cs_n && sclk !== sclk_prev) begin
      if (sclk != cur_mode.cpol) begin
        lead_t = $time;
        if (s_cnt == 0) begin
          s_tx = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
        end
        if (!cur_mode.cpha) begin
          s_rx = {s_rx[6:0], mosi};
          s_cnt++;
        end else begin
          miso <= s_tx[7-s_cnt];
        end
      end else begin
        check("sclk half-period", 32'($time - lead_t), (cur_hd + 1) * 40);
        if (!cur_mode.cpha) begin
          if (s_cnt == 8) begin
            mosi_q.push_back(s_rx);
            s_cnt = 0;
            miso  <= next_msb(); // next byte of a burst must be on miso before its first edge
          end else begin
            miso <= s_tx[7-s_cnt];
          end
        end else begin
          s_rx = {s_rx[6:0], mosi};
          s_cnt++;
          if (s_cnt == 8) begin
            mosi_q.push_back(s_rx);
            s_cnt = 0;
          end
        end
      end
    end
    cs_prev   = cs_n;
    sclk_prev = sclk;
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired before the tests completed");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    miso      = 1'b0;
    cur_mode  = 2'b00;
    cur_hd    = 8'd3;
    s_cnt     = 0;
    cs_rises  = 0;
    cs_prev   = 1'b1;
    sclk_prev = 1'b0;
    lead_t    = 0;
    s_tx      = '0;
    s_rx      = '0;
    void'($urandom(32'h4605_dbba));

    row_mode = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd0, 2'd0, 2'd3};
    row_hd   = '{8'd0, 8'd1, 8'd3, 8'd2, 8'd1, 8'd1, 8'd1, 8'd4};
    row_mb   = '{8'hA5, 8'h5A, 8'h81, 8'h0F, 8'h00, 8'h00, 8'h00, 8'h00};
    row_sb   = '{8'h3C, 8'hC3, 8'h7E, 8'hF0, 8'h00, 8'h00, 8'h00, 8'h00};
    row_last = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};
    for (i = 4; i < NROWS; i++) begin
      row_mb[i] = 8'($urandom());
      row_sb[i] = 8'($urandom());
    end
    for (i = 0; i < 8; i++) begin
      bp_m[i] = 8'($urandom());
      bp_s[i] = 8'($urandom());
    end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("cs_n", cs_n, 1);
    check("sclk", sclk, 0);
    check("pslverr", pslverr, 0);
    wait_status(32'h77, 32'h04);

    // rows up to the one with last set form one chip-select burst
    i = 0;
    while (i < NROWS) begin
      first = i;
      set_conf(row_mode[first], row_hd[first]);
      rises0 = cs_rises;
      n = 0;
      do begin
        miso_q.push_back(row_sb[i]);
        apb_write(REG_TXDATA, {23'h0, row_last[i], row_mb[i]}, err);
        check("pslverr", err, 0);
        i++;
        n++;
      end while (!row_last[i-1]);
      wait_status(32'h77, n << 4);
      check("cs_n", cs_n, 1);
      check("sclk", sclk, row_mode[first].cpol);
      check("cs_n rises", cs_rises - rises0, 1);
      for (int k = first; k < i; k++) begin
        read_rx(row_sb[k], row_mb[k]);
      end
    end

    // fill the receive queue, then overflow the transmit queue
    set_conf(2'd0, 8'd0);
    for (i = 0; i < 8; i++) begin
      miso_q.push_back(bp_s[i]);
    end
    for (i = 0; i < 4; i++) begin
      apb_write(REG_TXDATA, {23'h0, 1'b1, bp_m[i]}, err);
      check("pslverr", err, 0);
    end
    wait_status(32'h77, 32'h40);
    for (i = 4; i < 8; i++) begin
      apb_write(REG_TXDATA, {23'h0, 1'b1, bp_m[i]}, err);
      check("pslverr", err, 0);
    end
    apb_write(REG_TXDATA, {23'h0, 1'b1, 8'hEE}, err);
    check("pslverr", err, 1);
    wait_status(32'h77, 32'h42);
    repeat (40) @(posedge clk);
    apb_read(REG_STATUS, rdata, err);
    check("pslverr", err, 0);
    check("status", rdata & 32'h77, 32'h42);  // still stalled with the entries kept
    for (i = 0; i < 8; i++) begin
      wait_status(32'h04, 32'h00);
      read_rx(bp_s[i], bp_m[i]);
    end
    wait_status(32'h77, 32'h04);
    apb_read(REG_RXDATA, rdata, err);
    check("prdata", rdata, 0);
    check("pslverr", err, 1);
    check("mosi_q size", mosi_q.size(), 0);

    // conf is locked while a byte is in flight
    set_conf(2'd0, 8'd20);
    miso_q.push_back(8'h96);
    apb_write(REG_TXDATA, {23'h0, 1'b1, 8'h69}, err);
    check("pslverr", err, 0);
    apb_write(REG_CONF, 32'h0000_0003, err);
    check("pslverr", err, 1);
    apb_read(REG_CONF, rdata, err);
    check("pslverr", err, 0);
    check("conf", rdata, 32'h0000_1400);
    wait_status(32'h77, 32'h10);
    read_rx(8'h96, 8'h69);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== dv/spi_properties.sv ====
`timescale 1ns/1ns

module spi_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        psel,
  input logic        penable,
  input logic        pready,
  input logic        pslverr,
  input logic        sclk,
  input logic        mosi,
  input logic        cs_n,
  input logic        done,
  input logic [15:0] conf
);

  a_pready: assert property (@(posedge clk) disable iff (!rst_n) psel |-> pready)
    else $error("pready low during a selected APB cycle");

  // idle sclk follows cpol one cycle after conf changes
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (cs_n && $past(cs_n) && $past(conf) == $past(conf, 2)) |-> $stable(sclk))
    else $error("sclk moved while chip select was high");

  a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!cs_n && !done && $past(!done) && $stable(sclk)) |-> $stable(mosi))
    else $error("mosi changed without an sclk edge");

  a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable) |-> !pslverr)
    else $error("pslverr outside an access cycle");

endmodule

bind spi_master_top spi_properties u_props (
  .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pready(pready),
  .pslverr(pslverr), .sclk(sclk), .mosi(mosi), .cs_n(cs_n), .done(done), .conf(conf)
);

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module spi_master_tb -o sim_spi --Mdir obj_dir

if ./obj_dir/sim_spi | tee /dev/stderr | grep -q "Simulation PASSED"; then
  exit 0
else
  exit 1
fi

// ==== spi/spi_ctrl.sv ====
`timescale 1ns/1ns

module spi_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   tx_empty,
  input  spi_pkg::spi_tx_entry_t tx_entry,
  output logic                   tx_pop,
  input  logic                   rx_full,
  output logic                   rx_push,
  input  logic                   done,
  output logic                   start,
  output logic                   cs_n,
  output logic                   busy,
  input  logic [7:0]             half_div
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SELECT,
    ST_RUN,
    ST_DESELECT
  } state_t;

  state_t     state;
  logic       last_q;
  logic [7:0] gap_cnt;

  assign busy    = (state != ST_IDLE);
  assign start   = (state == ST_SELECT) && done && !rx_full;
  assign tx_pop  = start;                    // the head entry leaves as its byte starts
  assign rx_push = (state == ST_RUN) && done;

  // cs_n falls one cycle before start, the transceiver adds a half-period before the
  // first edge, and gap_cnt holds cs_n low for a half-period after the last edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      cs_n    <= 1'b1;
      last_q  <= 1'b0;
      gap_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          gap_cnt <= '0;
          if (!tx_empty && !rx_full) begin
            cs_n  <= 1'b0;
            state <= ST_SELECT;
          end
        end
        ST_SELECT: begin
          if (rx_full) begin
            state <= ST_DESELECT; // no room for the reply so the slave is let go
          end else if (done) begin
            last_q <= tx_entry.last;
            state  <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (done) begin
            state <= (last_q || tx_empty) ? ST_DESELECT : ST_SELECT;
          end
        end
        ST_DESELECT: begin
          if (gap_cnt == half_div) begin
            gap_cnt <= '0;
            cs_n    <= 1'b1;
            state   <= ST_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 8'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== spi/spi_xcvr.sv ====
`timescale 1ns/1ns
`include "spi_macros.svh"

module spi_xcvr (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [15:0]            conf,
  input  logic                   start,
  input  logic [`SPI_DATA_W-1:0] tx,
  output logic [`SPI_DATA_W-1:0] rx,
  output logic                   done,
  input  logic                   miso,
  output logic                   mosi,
  output logic                   sclk
);
  import spi_pkg::*;

  localparam int BW = $clog2(`SPI_DATA_W);
  localparam spi_conf_t CONF_RST = `SPI_CONF_RESET;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LEAD,
    ST_TRAIL
  } state_t;

  state_t               state;
  state_t               state_next;
  logic [`SPI_DATA_W:0] buffer;
  logic [`SPI_DATA_W:0] buffer_next;
  logic                 sclk_next;
  logic [BW-1:0]        bits;
  logic [BW-1:0]        bits_next;
  logic [7:0]           div_cnt;
  logic                 tick;
  spi_conf_t            cfg;

  assign cfg  = spi_conf_t'(conf);
  assign done = (state == ST_IDLE);
  assign mosi = buffer[`SPI_DATA_W];

  // with cpha set the byte is loaded one place lower, so it ends up in the low bits
  assign rx = cfg.mode.cpha ? buffer[`SPI_DATA_W-1:0] : buffer[`SPI_DATA_W:1];

  // one tick per sclk half-period, the count only runs during a transfer
  assign tick = (state != ST_IDLE) && (div_cnt == cfg.half_div);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (state == ST_IDLE || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= ST_IDLE;
      buffer <= '0;
      sclk   <= CONF_RST.mode.cpol;
      bits   <= '0;
    end else begin
      state  <= state_next;
      buffer <= buffer_next;
      sclk   <= sclk_next;
      bits   <= bits_next;
    end
  end

  always_comb begin
    state_next  = state;
    buffer_next = buffer;
    sclk_next   = sclk;
    bits_next   = bits;
    case (state)
      ST_IDLE: begin
        sclk_next = cfg.mode.cpol;
        if (start) begin
          // for cpha 1 the first bit goes out on the leading edge
          buffer_next = cfg.mode.cpha ? {1'b0, tx} : {tx, 1'b0};
          bits_next   = BW'(`SPI_DATA_W - 1);
          state_next  = ST_LEAD;
        end
      end
      ST_LEAD: begin
        if (tick) begin
          if (cfg.mode.cpha) begin
            buffer_next = {buffer[`SPI_DATA_W-1:0], 1'b0};
          end else begin
            buffer_next[0] = miso;
          end
          sclk_next  = ~sclk;
          state_next = ST_TRAIL;
        end
      end
      ST_TRAIL: begin
        if (tick) begin
          if (cfg.mode.cpha) begin
            buffer_next[0] = miso;
          end else begin
            buffer_next = {buffer[`SPI_DATA_W-1:0], 1'b0};
          end
          sclk_next = ~sclk;
          bits_next = bits - 1'b1;
          state_next = (bits == '0) ? ST_IDLE : ST_LEAD; // eighth trailing edge ends it
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/spi_pkg.sv
design/spi_fifo.sv
spi/spi_xcvr.sv
spi/spi_ctrl.sv
design/apb_spi_regs.sv
design/spi_master_top.sv
dv/spi_properties.sv
dv/spi_master_tb.sv
